/* sources.f */
+incdir+verif
src/snd_pkg.sv
src/snd_regs.sv
src/adpcm_voice.sv
src/rom_arbiter.sv
src/snd_mixer.sv
src/snd_top.sv
verif/snd_tb.sv

/* run.sh */
#!/bin/sh
# build the sound block testbench with verilator, run it, then look for the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module snd_tb -f sources.f --Mdir obj_dir

./obj_dir/Vsnd_tb 2>&1 | tee sim.log

grep -q "Test passed" sim.log

/* verif/snd_model.svh */
// reference adpcm decoder, mixer model and typed compare tasks, included inside the testbench module
`ifndef SND_MODEL_SVH
`define SND_MODEL_SVH

// one msm5205 nibble, signal and step index updated in place
task automatic decode_nibble(input logic [3:0] nib, inout int sig, inout int idx);
    int step;
    int diff;
    step = int'(step_table[idx]);
    diff = step / 8;
    if (nib[0])
        diff += step / 4;
    if (nib[1])
        diff += step / 2;
    if (nib[2])
        diff += step;
    sig = nib[3] ? sig - diff : sig + diff;
    sig = (sig > 2047) ? 2047 : (sig < -2048) ? -2048 : sig; // 12-bit signed range
    idx = idx + int'(index_adj[nib[2:0]]);
    idx = (idx < 0) ? 0 : (idx > 48) ? 48 : idx;
endtask

// expected voice values for a whole range, pulse 0 is the first nibble
task automatic load_voice(input int v, input logic [ROM_AW-1:0] first,
                          input logic [ROM_AW-1:0] last);
    int sig;
    int idx;
    int n;
    int a;
    sig = 0;
    idx = 0;
    n   = 0;
    for (a = int'(first); a <= int'(last); a++) begin
        decode_nibble(rom_mem[a][7:4], sig, idx); // high nibble first
        exp_seq[v][n] = sig;
        n++;
        decode_nibble(rom_mem[a][3:0], sig, idx);
        exp_seq[v][n] = sig;
        n++;
    end
    seq_len[v] = n;
    seq_pos[v] = 0;
endtask

// sum at the next sample pulse, each voice x8, silent once its sequence is over
task automatic mix_expected(output logic signed [SND_W-1:0] exp_snd);
    int total;
    total = 0;
    for (int v = 0; v < NVOICE; v++) begin
        if (seq_pos[v] < seq_len[v])
            total += exp_seq[v][seq_pos[v]] * 8;
        seq_pos[v]++;
    end
    exp_snd = SND_W'(total);
endtask

task automatic check_sound(input string name, input logic signed [SND_W-1:0] exp_v,
                           input logic signed [SND_W-1:0] act_v);
    if (act_v !== exp_v) begin
        $display("FAIL %s: expected %0d, actual %0d", name, exp_v, act_v);
        abort_run();
    end
endtask

task automatic check_word(input string name, input logic [31:0] exp_v,
                          input logic [31:0] act_v);
    if (act_v !== exp_v) begin
        $display("FAIL %s: expected %08h, actual %08h", name, exp_v, act_v);
        abort_run();
    end
endtask

task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
        $display("FAIL %s: expected %b, actual %b", name, exp_v, act_v);
        abort_run();
    end
endtask

`endif

/* verif/snd_tb.sv */
// testbench for the two-voice sound block with an apb host, a random-latency rom and model checks
`timescale 1ns/1ps

module snd_tb;
    import snd_pkg::*;

    localparam int CLK_DIV = 64;
    localparam int NROW    = 5;
    localparam int TMO     = 2 * CLK_DIV; // cycles allowed per wait

    // numeric part of one stimulus row
    typedef struct packed {
        logic [ROM_AW-1:0] s0;
        logic [ROM_AW-1:0] e0;
        logic [ROM_AW-1:0] s1;
        logic [ROM_AW-1:0] e1;
        logic [1:0]        start_mask;
        logic [1:0]        stop_mask;    // mid-run stop
        logic [1:0]        restart_mask; // mid-run restart with rs..re
        logic [ROM_AW-1:0] rs;
        logic [ROM_AW-1:0] re;
        logic [7:0]        act_after;    // pulses before the mid-run command or 0 for none
        logic [7:0]        nsamp;
    } row_t;

    logic                    clk = 1'b0;
    logic                    arst_n = 1'b0;
    apb_req_t                apb_req = '0;
    apb_rsp_t                apb_rsp;
    rom_req_t                rom_req;
    rom_rsp_t                rom_rsp = '0;
    logic signed [SND_W-1:0] sound;
    logic                    sample;
    logic                    irq;

    logic [7:0] rom_mem [65536];
    int         rom_wait = 0;
    logic       rom_busy = 1'b0;
    int         exp_seq [NVOICE][512]; // model voice values per pulse
    int         seq_len [NVOICE];
    int         seq_pos [NVOICE];
    row_t       rows [NROW];
    string      test_name [NROW];

    snd_top #(
        .CLK_DIV ( CLK_DIV )
    ) u_dut (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .apb_req ( apb_req ),
        .apb_rsp ( apb_rsp ),
        .rom_req ( rom_req ),
        .rom_rsp ( rom_rsp ),
        .sound   ( sound   ),
        .sample  ( sample  ),
        .irq     ( irq     )
    );

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    `include "snd_model.svh"

    // sample rom answering 1 to 8 cycles after cs
    always @(negedge clk) begin
        if (rom_rsp.ok) begin
            rom_rsp.ok = 1'b0; // single cycle
        end else if (rom_req.cs) begin
            if (!rom_busy) begin
                rom_busy = 1'b1;
                rom_wait = $urandom % 8;
            end
            if (rom_wait == 0) begin
                rom_rsp.data = rom_mem[rom_req.addr];
                rom_rsp.ok   = 1'b1;
                rom_busy     = 1'b0;
            end else begin
                rom_wait--;
            end
        end
    end

    // one apb3 transfer from a falling edge with the response taken in the access phase
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_bit("apb pready", 1'b1, apb_rsp.pready); // zero wait states
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_write(input string name, input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, wdata, rd, err);
        check_bit({name, " write pslverr"}, 1'b0, err);
    endtask

    task automatic apb_read(input string name, input logic [7:0] addr, output logic [31:0] rdata);
        logic err;
        apb_xfer(1'b0, addr, 32'h0, rdata, err);
        check_bit({name, " read pslverr"}, 1'b0, err);
    endtask

    // compares the next sample pulse with the model and returns in that cycle
    task automatic check_pulse(input string name);
        logic signed [SND_W-1:0] exp_snd;
        int                      n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!sample && n < TMO);
        if (!sample) begin
            $display("timeout waiting for sample pulse in %s", name);
            abort_run();
        end
        mix_expected(exp_snd);
        check_sound(name, exp_snd, sound);
    endtask

    task automatic fill_table();
        test_name[0] = "single_voice0";
        rows[0] = '{16'h0100, 16'h010f, 16'h0000, 16'h0000, 2'b01, 2'b00, 2'b00,
                    16'h0000, 16'h0000, 8'd0, 8'd36};
        test_name[1] = "single_voice1";
        rows[1] = '{16'h0000, 16'h0000, 16'h2000, 16'h2007, 2'b10, 2'b00, 2'b00,
                    16'h0000, 16'h0000, 8'd0, 8'd20};
        test_name[2] = "both_voices";
        rows[2] = '{16'h0400, 16'h0417, 16'h0800, 16'h080b, 2'b11, 2'b00, 2'b00,
                    16'h0000, 16'h0000, 8'd0, 8'd52};
        test_name[3] = "stop_voice1";
        rows[3] = '{16'h1000, 16'h101f, 16'h3000, 16'h301f, 2'b11, 2'b10, 2'b00,
                    16'h0000, 16'h0000, 8'd10, 8'd30};
        test_name[4] = "restart_voice0";
        rows[4] = '{16'h5000, 16'h501f, 16'h6000, 16'h6007, 2'b11, 2'b00, 2'b01,
                    16'h7000, 16'h7005, 8'd7, 8'd24};
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [31:0] wd;
        row_t        r;
        string       tn;
        logic [1:0]  bz; // expected busy
        logic [1:0]  dn; // expected done
        void'($urandom(32'h6be8eef5));
        for (int a = 0; a < 65536; a++) begin
            rom_mem[a] = 8'($urandom);
        end
        for (int v = 0; v < NVOICE; v++) begin
            seq_len[v] = 0;
            seq_pos[v] = 0;
        end
        fill_table();
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // reset state, register readback and bus errors
        check_bit("irq after reset", 1'b0, irq);
        check_bit("sample after reset", 1'b0, sample);
        check_bit("rom cs after reset", 1'b0, rom_req.cs);
        check_sound("sound after reset", '0, sound);
        apb_read("status after reset", 8'h14, rd);
        check_word("status after reset", 32'h0, rd);
        for (int i = 0; i < 4; i++) begin
            wd = 32'hdead0000 | (32'(i) * 32'h1357 + 32'h0101);
            apb_write("cfg write", 8'(4 * i), wd);
        end
        for (int i = 0; i < 4; i++) begin
            wd = 32'hdead0000 | (32'(i) * 32'h1357 + 32'h0101);
            apb_read("cfg readback", 8'(4 * i), rd);
            check_word("cfg readback", {16'h0, wd[15:0]}, rd); // upper bits dropped
        end
        apb_xfer(1'b0, 8'h20, 32'h0, rd, err);
        check_bit("read 0x20 pslverr", 1'b1, err);
        apb_xfer(1'b1, 8'h20, 32'h0, rd, err);
        check_bit("write 0x20 pslverr", 1'b1, err);
        apb_xfer(1'b1, 8'h14, 32'h0, rd, err);
        check_bit("write 0x14 pslverr", 1'b1, err);

        for (int t = 0; t < NROW; t++) begin
            r  = rows[t];
            tn = test_name[t];
            apb_write(tn, 8'h00, 32'(r.s0));
            apb_write(tn, 8'h04, 32'(r.e0));
            apb_write(tn, 8'h08, 32'(r.s1));
            apb_write(tn, 8'h0c, 32'(r.e1));
            check_pulse(tn); // start right after a pulse so the first tick finds a byte
            apb_write(tn, 8'h10, 32'(r.start_mask));
            if (r.start_mask[0])
                load_voice(0, r.s0, r.e0);
            if (r.start_mask[1])
                load_voice(1, r.s1, r.e1);
            apb_read(tn, 8'h14, rd);
            check_word({tn, " busy"}, 32'(r.start_mask), rd);
            for (int k = 1; k <= int'(r.nsamp); k++) begin
                check_pulse(tn);
                if (k == int'(r.act_after)) begin
                    for (int v = 0; v < NVOICE; v++) begin
                        if (r.restart_mask[v]) begin
                            apb_write(tn, 8'(8 * v), 32'(r.rs));
                            apb_write(tn, 8'(8 * v + 4), 32'(r.re));
                        end
                    end
                    apb_write(tn, 8'h10, 32'({r.stop_mask, 2'b00, r.restart_mask}));
                    for (int v = 0; v < NVOICE; v++) begin
                        if (r.stop_mask[v])
                            seq_len[v] = 0; // silent from the next pulse
                        if (r.restart_mask[v])
                            load_voice(v, r.rs, r.re);
                    end
                end
            end
            // finished voices are done but stopped ones are not
            for (int v = 0; v < NVOICE; v++) begin
                bz[v] = seq_pos[v] < seq_len[v];
                dn[v] = (r.start_mask[v] || r.restart_mask[v]) && !r.stop_mask[v] && !bz[v];
            end
            apb_read(tn, 8'h14, rd);
            check_word({tn, " status"}, 32'({dn, 6'b000000, bz}), rd);
            check_bit({tn, " irq"}, |dn, irq);
            apb_xfer(1'b1, 8'h14, 32'({dn, 8'h00}), rd, err); // w1c on done
            check_bit({tn, " done clear pslverr"}, 1'b1, err);
            check_bit({tn, " irq cleared"}, 1'b0, irq);
            apb_write(tn, 8'h10, 32'h30);
            for (int v = 0; v < NVOICE; v++) begin
                seq_len[v] = 0;
            end
        end

        $display("Test passed");
        $finish;
    end

endmodule

/* src/snd_top.sv */
// two-voice adpcm sound block top: apb registers, voices, sample rom arbiter and mixer
`timescale 1ns/1ps

module snd_top #(
    parameter int CLK_DIV = 64 // clocks per output sample
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  snd_pkg::apb_req_t                apb_req,
    output snd_pkg::apb_rsp_t                apb_rsp,
    output snd_pkg::rom_req_t                rom_req, // external sample rom
    input  snd_pkg::rom_rsp_t                rom_rsp,
    output logic signed [snd_pkg::SND_W-1:0] sound,
    output logic                             sample,
    output logic                             irq
);
    import snd_pkg::*;

    voice_cfg_t                cfg [NVOICE];
    logic [NVOICE-1:0]         start;
    logic [NVOICE-1:0]         stop;
    logic [NVOICE-1:0]         busy;
    logic [NVOICE-1:0]         voice_end;
    logic                      sample_tick;
    rom_req_t                  voice_req [NVOICE];
    rom_rsp_t                  voice_rsp [NVOICE];
    logic signed [VOICE_W-1:0] voice_signal [NVOICE];

    snd_regs u_regs (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .apb_req   ( apb_req   ),
        .apb_rsp   ( apb_rsp   ),
        .cfg       ( cfg       ),
        .start     ( start     ),
        .stop      ( stop      ),
        .busy      ( busy      ),
        .voice_end ( voice_end ),
        .irq       ( irq       )
    );

    adpcm_voice u_voice0 (
        .clk         ( clk             ),
        .arst_n      ( arst_n          ),
        .cfg         ( cfg[0]          ),
        .start       ( start[0]        ),
        .stop        ( stop[0]         ),
        .sample_tick ( sample_tick     ),
        .rom_req     ( voice_req[0]    ),
        .rom_rsp     ( voice_rsp[0]    ),
        .busy        ( busy[0]         ),
        .voice_end   ( voice_end[0]    ),
        .signal      ( voice_signal[0] )
    );

    adpcm_voice u_voice1 (
        .clk         ( clk             ),
        .arst_n      ( arst_n          ),
        .cfg         ( cfg[1]          ),
        .start       ( start[1]        ),
        .stop        ( stop[1]         ),
        .sample_tick ( sample_tick     ),
        .rom_req     ( voice_req[1]    ),
        .rom_rsp     ( voice_rsp[1]    ),
        .busy        ( busy[1]         ),
        .voice_end   ( voice_end[1]    ),
        .signal      ( voice_signal[1] )
    );

    rom_arbiter u_arbiter (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .voice_req ( voice_req ),
        .voice_rsp ( voice_rsp ),
        .rom_req   ( rom_req   ),
        .rom_rsp   ( rom_rsp   )
    );

    snd_mixer #(
        .CLK_DIV ( CLK_DIV )
    ) u_mixer (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .voice_signal ( voice_signal ),
        .sample_tick  ( sample_tick  ),
        .sound        ( sound        ),
        .sample       ( sample       )
    );

endmodule

/* src/snd_mixer.sv */
// sample-rate timer and voice mixer producing the 16-bit sound output and its strobe
`timescale 1ns/1ps

module snd_mixer #(
    parameter int CLK_DIV = 64
) (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic signed [snd_pkg::VOICE_W-1:0] voice_signal [snd_pkg::NVOICE],
    output logic                               sample_tick,
    output logic signed [snd_pkg::SND_W-1:0]   sound,
    output logic                               sample
);
    import snd_pkg::*;

    localparam int CNT_W = $clog2(CLK_DIV);

    logic [CNT_W-1:0]        cnt_q;
    logic                    tick_d; // voices already hold the new nibble
    logic signed [SND_W-1:0] sum;

    // one sign bit of headroom, x8 as on the board
    always_comb begin
        sum = '0;
        for (int i = 0; i < NVOICE; i++) begin
            sum = sum + $signed({voice_signal[i][VOICE_W-1], voice_signal[i], 3'b000});
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q       <= '0;
            sample_tick <= 1'b0;
            tick_d      <= 1'b0;
            sample      <= 1'b0;
            sound       <= '0;
        end else begin
            sample_tick <= cnt_q == CNT_W'(CLK_DIV - 1); // first tick CLK_DIV cycles in
            cnt_q       <= (cnt_q == CNT_W'(CLK_DIV - 1)) ? '0 : cnt_q + 1'b1;
            tick_d      <= sample_tick;
            sample      <= tick_d; // strobe in the cycle sound changes
            if (tick_d) begin
                sound <= sum;
            end
        end
    end

endmodule

/* src/rom_arbiter.sv */
// shares the external sample rom port between the voices round-robin with one transfer open
`timescale 1ns/1ps

module rom_arbiter (
    input  logic              clk,
    input  logic              arst_n,
    input  snd_pkg::rom_req_t voice_req [snd_pkg::NVOICE],
    output snd_pkg::rom_rsp_t voice_rsp [snd_pkg::NVOICE],
    output snd_pkg::rom_req_t rom_req,
    input  snd_pkg::rom_rsp_t rom_rsp
);
    import snd_pkg::*;

    logic              act_q;  // transfer open on the shared port
    logic              gnt_q;  // voice owning it
    logic              prio_q; // tie winner with voice 0 first after reset
    logic              pick;
    logic [NVOICE-1:0] ok_vec;

    always_comb begin
        if (voice_req[0].cs && voice_req[1].cs) begin
            pick = prio_q;
        end else begin
            pick = voice_req[1].cs; // lone requester
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            act_q  <= 1'b0;
            gnt_q  <= 1'b0;
            prio_q <= 1'b0;
        end else if (act_q) begin
            if (rom_rsp.ok) begin
                act_q <= 1'b0; // voice cs drops on this same edge
            end
        end else if (voice_req[0].cs || voice_req[1].cs) begin
            act_q  <= 1'b1;
            gnt_q  <= pick;
            prio_q <= !pick; // other voice wins the next tie
        end
    end

    assign rom_req.cs   = act_q;
    assign rom_req.addr = voice_req[gnt_q].addr;

    // data fans out to both and ok only to the owner
    always_comb begin
        for (int i = 0; i < NVOICE; i++) begin
            ok_vec[i]         = act_q && rom_rsp.ok && gnt_q == 1'(i);
            voice_rsp[i].data = rom_rsp.data;
            voice_rsp[i].ok   = ok_vec[i];
        end
    end

    // rom answers only an open transfer so ok reaches the one owner
    a_one_ok: assert property (@(posedge clk) disable iff (!arst_n)
        rom_rsp.ok |-> act_q);

endmodule

/* src/adpcm_voice.sv */
// one adpcm voice that walks its rom range and decodes a prefetched byte a nibble per tick
`timescale 1ns/1ps

module adpcm_voice (
    input  logic                               clk,
    input  logic                               arst_n,
    input  snd_pkg::voice_cfg_t                cfg,
    input  logic                               start,
    input  logic                               stop,
    input  logic                               sample_tick,
    output snd_pkg::rom_req_t                  rom_req,
    input  snd_pkg::rom_rsp_t                  rom_rsp,
    output logic                               busy,
    output logic                               voice_end,
    output logic signed [snd_pkg::VOICE_W-1:0] signal
);
    import snd_pkg::*;

    localparam logic signed [13:0] SIG_MAX = 14'sd2047;
    localparam logic signed [13:0] SIG_MIN = -14'sd2048;

    logic               cs_q;        // request open on the rom port
    logic               disc_q;      // open request belongs to an old run
    logic [ROM_AW-1:0]  req_addr_q;  // stable while cs_q
    logic [ROM_AW-1:0]  next_addr_q; // byte to fetch next
    logic [ROM_AW-1:0]  end_q;       // range end latched at start
    logic [7:0]         buf_q;       // prefetched byte
    logic               buf_vld;
    logic               buf_last;    // buffered byte sits at end_addr
    logic               lo_sel;      // low nibble is next
    logic [5:0]         idx_q;       // step index 0..48
    logic               issue;
    logic               take;
    logic               consume;
    logic [3:0]         nib;
    logic [10:0]        step;
    logic [11:0]        diff;        // at most 2910
    logic signed [13:0] sum;
    logic signed [6:0]  idx_sum;
    logic [5:0]         idx_nxt;

    assign issue   = !cs_q && busy && !buf_vld && !start && !stop;
    assign take    = rom_rsp.ok && !disc_q && !start && !stop; // stale data dropped
    assign consume = sample_tick && busy && buf_vld && !start && !stop;
    assign nib     = lo_sel ? buf_q[3:0] : buf_q[7:4]; // high nibble first
    assign step    = step_table[idx_q];

    assign rom_req.cs   = cs_q;
    assign rom_req.addr = req_addr_q;

    // msm5205 decode of one nibble
    always_comb begin
        diff = 12'(step >> 3);
        if (nib[0]) begin
            diff = diff + 12'(step >> 2);
        end
        if (nib[1]) begin
            diff = diff + 12'(step >> 1);
        end
        if (nib[2]) begin
            diff = diff + 12'(step);
        end
        sum = 14'(signal); // sign extended
        if (nib[3]) begin
            sum = sum - $signed({2'b00, diff});
        end else begin
            sum = sum + $signed({2'b00, diff});
        end
        if (sum > SIG_MAX) begin
            sum = SIG_MAX;
        end else if (sum < SIG_MIN) begin
            sum = SIG_MIN;
        end
        idx_sum = $signed({1'b0, idx_q}) + 7'(index_adj[nib[2:0]]);
        if (idx_sum < 0) begin
            idx_nxt = '0;
        end else if (idx_sum > 7'sd48) begin
            idx_nxt = 6'd48;
        end else begin
            idx_nxt = idx_sum[5:0];
        end
    end

    // cs falls the cycle after ok
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cs_q   <= 1'b0;
            disc_q <= 1'b0;
        end else if (rom_rsp.ok) begin
            cs_q   <= 1'b0;
            disc_q <= 1'b0;
        end else begin
            if (issue) begin
                cs_q <= 1'b1;
            end
            if (cs_q && (start || stop)) begin
                disc_q <= 1'b1; // transfer finishes and its byte is ignored
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr_q <= next_addr_q;
        end
        if (start) begin
            next_addr_q <= cfg.start_addr;
            end_q       <= cfg.end_addr;
        end else if (take) begin
            next_addr_q <= req_addr_q + 1'b1;
        end
        if (take) begin
            buf_q <= rom_rsp.data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            voice_end <= 1'b0;
            signal    <= '0;
            idx_q     <= '0;
            buf_vld   <= 1'b0;
            buf_last  <= 1'b0;
            lo_sel    <= 1'b0;
        end else begin
            voice_end <= 1'b0;
            if (start) begin // also restarts a busy voice
                busy    <= 1'b1;
                signal  <= '0;
                idx_q   <= '0;
                buf_vld <= 1'b0;
                lo_sel  <= 1'b0;
            end else if (stop) begin
                busy    <= 1'b0;
                signal  <= '0;
                buf_vld <= 1'b0;
            end else begin
                if (take) begin
                    buf_vld  <= 1'b1;
                    buf_last <= req_addr_q == end_q;
                end
                if (consume) begin
                    signal <= sum[VOICE_W-1:0];
                    idx_q  <= idx_nxt;
                    lo_sel <= !lo_sel;
                    if (lo_sel) begin
                        buf_vld <= 1'b0; // next fetch goes out now
                        if (buf_last) begin
                            busy      <= 1'b0;
                            voice_end <= 1'b1;
                        end
                    end
                end else if (sample_tick && !busy) begin
                    signal <= '0; // back to silence once the last value is sampled
                end
            end
        end
    end

    a_range: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> cfg.start_addr <= cfg.end_addr);

endmodule

/* src/snd_regs.sv */
// apb register block of the sound core: voice ranges, start/stop commands, status and irq
`timescale 1ns/1ps

module snd_regs (
    input  logic                       clk,
    input  logic                       arst_n,
    input  snd_pkg::apb_req_t          apb_req,
    output snd_pkg::apb_rsp_t          apb_rsp,
    output snd_pkg::voice_cfg_t        cfg [snd_pkg::NVOICE],
    output logic [snd_pkg::NVOICE-1:0] start,     // one-cycle pulse per voice
    output logic [snd_pkg::NVOICE-1:0] stop,
    input  logic [snd_pkg::NVOICE-1:0] busy,
    input  logic [snd_pkg::NVOICE-1:0] voice_end,
    output logic                       irq
);
    import snd_pkg::*;

    localparam logic [7:0] ADDR_CTRL = 8'h10; // write-only
    localparam logic [7:0] ADDR_STAT = 8'h14; // read, w1c on done

    logic              access;   // apb access phase
    logic              wr;
    logic              in_cfg;   // 0x00..0x0c
    logic              is_ctrl;
    logic              is_stat;
    logic              mapped;
    logic              vsel;     // voice of a cfg access
    logic              esel;     // end rather than start address
    logic [NVOICE-1:0] done_q;   // sticky finish flags
    logic [NVOICE-1:0] done_clr;

    assign access  = apb_req.psel & apb_req.penable;
    assign wr      = access & apb_req.pwrite;
    assign in_cfg  = apb_req.paddr[7:4] == 4'h0 && apb_req.paddr[1:0] == 2'b00;
    assign is_ctrl = apb_req.paddr == ADDR_CTRL;
    assign is_stat = apb_req.paddr == ADDR_STAT;
    assign mapped  = in_cfg | is_ctrl | is_stat;
    assign vsel    = apb_req.paddr[3];
    assign esel    = apb_req.paddr[2];

    // voice address ranges, kept to rom width
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NVOICE; i++) begin
                cfg[i] <= '0;
            end
        end else if (wr && in_cfg) begin
            if (esel) begin
                cfg[vsel].end_addr <= apb_req.pwdata[ROM_AW-1:0];
            end else begin
                cfg[vsel].start_addr <= apb_req.pwdata[ROM_AW-1:0];
            end
        end
    end

    // control write becomes start/stop pulses, voices act on the next edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start <= '0;
            stop  <= '0;
        end else begin
            start <= (wr && is_ctrl) ? apb_req.pwdata[0 +: NVOICE] : '0;
            stop  <= (wr && is_ctrl) ? apb_req.pwdata[4 +: NVOICE] : '0;
        end
    end

    assign done_clr = (wr && is_stat) ? apb_req.pwdata[8 +: NVOICE] : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_q <= '0;
        end else begin
            done_q <= (done_q & ~done_clr) | voice_end; // a new end beats the clear
        end
    end

    assign irq = |done_q;

    // zero wait state response
    always_comb begin
        apb_rsp         = '0;
        apb_rsp.pready  = 1'b1;
        // status write still clears done, but is flagged
        apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && is_stat));
        if (in_cfg) begin
            apb_rsp.prdata[ROM_AW-1:0] = esel ? cfg[vsel].end_addr : cfg[vsel].start_addr;
        end else if (is_stat) begin
            apb_rsp.prdata[0 +: NVOICE] = busy;
            apb_rsp.prdata[8 +: NVOICE] = done_q;
        end
    end

    // apb3 access phase only inside a selected transfer
    a_penable_psel: assert property (@(posedge clk) disable iff (!arst_n)
        apb_req.penable |-> apb_req.psel);

endmodule

/* src/snd_pkg.sv */
// shared widths, bus structs and adpcm tables of the sound block, compiled before the rtl
package snd_pkg;

    localparam int ROM_AW  = 16; // sample rom byte address
    localparam int VOICE_W = 12; // decoded voice, signed
    localparam int SND_W   = 16; // mixed output, signed
    localparam int NVOICE  = 2;

    // master side of apb3, 43 bits
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;  // always 1, zero wait states
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [ROM_AW-1:0] start_addr; // first byte played
        logic [ROM_AW-1:0] end_addr;   // last byte played, inclusive
    } voice_cfg_t;

    typedef struct packed {
        logic              cs;   // held with a stable addr until ok
        logic [ROM_AW-1:0] addr;
    } rom_req_t;

    typedef struct packed {
        logic [7:0] data;
        logic       ok;   // single-cycle, qualifies data
    } rom_rsp_t;

    // msm5205 step sizes
    localparam logic [10:0] step_table [49] = '{
        11'd16,   11'd17,   11'd19,   11'd21,   11'd23,   11'd25,   11'd28,
        11'd31,   11'd34,   11'd37,   11'd41,   11'd45,   11'd50,   11'd55,
        11'd60,   11'd66,   11'd73,   11'd80,   11'd88,   11'd97,   11'd107,
        11'd118,  11'd130,  11'd143,  11'd157,  11'd173,  11'd190,  11'd209,
        11'd230,  11'd253,  11'd279,  11'd307,  11'd337,  11'd371,  11'd408,
        11'd449,  11'd494,  11'd544,  11'd598,  11'd658,  11'd724,  11'd796,
        11'd876,  11'd963,  11'd1060, 11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    // step index change, indexed by nibble magnitude bits 2:0
    localparam logic signed [4:0] index_adj [8] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1, 5'sd2, 5'sd4, 5'sd6, 5'sd8
    };

endpackage
